/* include/mips_consts.svh */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Widths ------------------------
`define MIPS_NB_DATA        32          // Register and memory word
`define MIPS_NB_REG_ADDR    5           // 32 registers
`define MIPS_NB_MEM_ADDR    7           // 128 words per memory
`define MIPS_NB_BYTE        8           // Loader byte

// Opcodes, instr[31:26] ---------
`define MIPS_OP_RTYPE       6'h00
`define MIPS_OP_ADDI        6'h08
`define MIPS_OP_LW          6'h23
`define MIPS_OP_SW          6'h2B
`define MIPS_OP_BEQ         6'h04
`define MIPS_OP_BNE         6'h05

// Function codes, instr[5:0] ----
`define MIPS_FN_ADDU        6'h21
`define MIPS_FN_SUBU        6'h23
`define MIPS_FN_AND         6'h24
`define MIPS_FN_OR          6'h25
`define MIPS_FN_SLT         6'h2A

`define MIPS_HALT_WORD      32'hFFFF_FFFF   // Stops the pipeline once decoded

`endif

/* rtl/mips_pkg.sv */
`include "mips_consts.svh"

package mips_pkg;

    typedef logic [`MIPS_NB_DATA-1:0]     data_t;
    typedef logic [`MIPS_NB_REG_ADDR-1:0] reg_addr_t;
    typedef logic [`MIPS_NB_MEM_ADDR-1:0] mem_addr_t;   // Word index, either memory
    typedef logic [`MIPS_NB_BYTE-1:0]     byte_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT                                         // Signed compare
    } alu_op_e;

    // Stage registers ------------
    typedef struct packed {
        data_t      instr;
        data_t      pc_plus_4;
    } if_id_t;

    typedef struct packed {
        data_t      op_a;           // Forwarded rs
        data_t      op_b;           // Forwarded rt, also store data
        data_t      imm;            // Sign extended
        reg_addr_t  dest;
        alu_op_e    alu_op;
        logic       alu_src;        // 1 selects imm for ALU input b
        logic       mem_write;
        logic       mem_read;
        logic       reg_write;
    } id_ex_t;

    typedef struct packed {
        data_t      alu_result;     // Also the data address
        data_t      store_data;
        reg_addr_t  dest;
        logic       mem_write;
        logic       mem_read;
        logic       reg_write;
    } ex_mem_t;

    typedef struct packed {
        data_t      wb_data;
        reg_addr_t  dest;
        logic       reg_write;
    } mem_wb_t;

endpackage

/* rtl/hazard_unit.sv */
module hazard_unit (
    input  mips_pkg::reg_addr_t i_rs,               // Sources of the instr in decode
    input  mips_pkg::reg_addr_t i_rt,
    input  logic                i_id_ex_mem_read,   // Load now in EX
    input  mips_pkg::reg_addr_t i_id_ex_dest,
    input  logic                i_branch_taken,
    input  logic                i_halted,
    output logic                o_stall,
    output logic                o_flush
);

    logic load_use;

    // Loaded word reaches MEM forwarding one cycle later
    assign load_use = i_id_ex_mem_read && (i_id_ex_dest != '0)
                      && (i_id_ex_dest == i_rs || i_id_ex_dest == i_rt);

    assign o_stall = load_use || i_halted;           // Halt freezes IF and ID
    assign o_flush = i_branch_taken && !o_stall;     // Branch operands valid only unstalled

endmodule

/* rtl/instruction_fetch.sv */
`include "mips_consts.svh"

module instruction_fetch (
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_pc_reset,
    input  mips_pkg::byte_t   i_load_program_byte,
    input  logic              i_load_program_write_enable,
    input  logic              i_stall,
    input  logic              i_flush,
    input  logic              i_branch_taken,
    input  mips_pkg::data_t   i_branch_target,
    output mips_pkg::if_id_t  o_if_id,
    output mips_pkg::data_t   o_pc
);

    mips_pkg::data_t                   prog_mem [0:(1 << `MIPS_NB_MEM_ADDR) - 1];
    logic [3*`MIPS_NB_BYTE-1:0]        byte_buf;     // Upper three bytes of the word
    logic [1:0]                        byte_cnt;     // Position within the word
    mips_pkg::mem_addr_t               wr_ptr;
    mips_pkg::data_t                   pc;
    mips_pkg::data_t                   pc_plus_4;

    // Loader ---------------------
    // MSB first, the fourth byte completes the word
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            byte_cnt <= '0;
            wr_ptr   <= '0;
        end else if (i_load_program_write_enable) begin
            byte_cnt <= byte_cnt + 2'd1;             // Wraps after 3
            byte_buf <= {byte_buf[2*`MIPS_NB_BYTE-1:0], i_load_program_byte};
            if (byte_cnt == 2'd3) begin
                prog_mem[wr_ptr] <= {byte_buf, i_load_program_byte};
                wr_ptr           <= wr_ptr + mips_pkg::mem_addr_t'(1);
            end
        end
    end

    // PC and IF/ID ---------------
    assign pc_plus_4 = pc + 32'd4;
    assign o_pc      = pc;

    always_ff @(posedge i_clock) begin
        if (i_reset || i_pc_reset) begin
            pc      <= '0;
            o_if_id <= '0;                               // NOP in decode
        end else if (!i_stall) begin
            pc <= i_branch_taken ? i_branch_target : pc_plus_4;
            if (i_flush)
                o_if_id.instr <= '0;                     // Drop the fetched word
            else
                o_if_id.instr <= prog_mem[pc[`MIPS_NB_MEM_ADDR+1:2]];
            o_if_id.pc_plus_4 <= pc_plus_4;
        end
    end

    // Program bytes arrive only while the pipeline sits idle
    a_no_stall_flush_in_load: assert property (
        @(posedge i_clock) disable iff (i_reset)
            i_load_program_write_enable |-> !(i_stall || i_flush)
    );

endmodule

/* rtl/instruction_decode.sv */
`include "mips_consts.svh"

module instruction_decode (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_pc_reset,
    input  mips_pkg::if_id_t    i_if_id,
    input  logic                i_stall,
    input  mips_pkg::data_t     i_ex_result,      // ALU output of the instr in EX
    input  mips_pkg::reg_addr_t i_ex_dest,
    input  logic                i_ex_reg_write,
    input  mips_pkg::data_t     i_mem_result,     // Write-back value of the instr in MEM
    input  mips_pkg::reg_addr_t i_mem_dest,
    input  logic                i_mem_reg_write,
    input  mips_pkg::mem_wb_t   i_mem_wb,         // Bank write and last forward source
    input  mips_pkg::reg_addr_t i_debug_read_reg_address,
    output mips_pkg::id_ex_t    o_id_ex,
    output mips_pkg::reg_addr_t o_rs,
    output mips_pkg::reg_addr_t o_rt,
    output logic                o_branch_taken,
    output mips_pkg::data_t     o_branch_target,
    output logic                o_halted,
    output mips_pkg::data_t     o_debug_read_reg
);

    mips_pkg::data_t     reg_bank [0:(1 << `MIPS_NB_REG_ADDR) - 1];
    mips_pkg::data_t     instr;
    logic [5:0]          opcode;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t rd;
    mips_pkg::data_t     imm_ext;
    mips_pkg::data_t     rs_data;              // After forwarding
    mips_pkg::data_t     rt_data;
    logic                is_beq;
    logic                is_bne;
    mips_pkg::id_ex_t    id_ex_next;

    assign instr   = i_if_id.instr;
    assign opcode  = instr[31:26];
    assign o_rs    = instr[25:21];
    assign o_rt    = instr[20:16];
    assign rd      = instr[15:11];
    assign funct   = instr[5:0];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};

    // Priority EX, MEM, WB, then the bank
    function automatic mips_pkg::data_t fwd(mips_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (i_ex_reg_write && i_ex_dest == addr)
            return i_ex_result;
        if (i_mem_reg_write && i_mem_dest == addr)
            return i_mem_result;
        if (i_mem_wb.reg_write && i_mem_wb.dest == addr)
            return i_mem_wb.wb_data;                 // Same-cycle bank write
        return reg_bank[addr];
    endfunction

    always_comb begin
        rs_data = fwd(o_rs);
        rt_data = fwd(o_rt);
    end

    // Branch resolves here ------
    assign o_branch_taken  = (is_beq && rs_data == rt_data) || (is_bne && rs_data != rt_data);
    assign o_branch_target = i_if_id.pc_plus_4 + {imm_ext[`MIPS_NB_DATA-3:0], 2'b00};

    // Control decode
    always_comb begin
        id_ex_next        = '0;
        id_ex_next.op_a   = rs_data;
        id_ex_next.op_b   = rt_data;
        id_ex_next.imm    = imm_ext;
        id_ex_next.dest   = rd;
        id_ex_next.alu_op = mips_pkg::ALU_ADD;
        is_beq            = 1'b0;
        is_bne            = 1'b0;
        case (opcode)
            `MIPS_OP_RTYPE: begin
                id_ex_next.reg_write = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: id_ex_next.alu_op = mips_pkg::ALU_ADD;
                    `MIPS_FN_SUBU: id_ex_next.alu_op = mips_pkg::ALU_SUB;
                    `MIPS_FN_AND:  id_ex_next.alu_op = mips_pkg::ALU_AND;
                    `MIPS_FN_OR:   id_ex_next.alu_op = mips_pkg::ALU_OR;
                    `MIPS_FN_SLT:  id_ex_next.alu_op = mips_pkg::ALU_SLT;
                    default:       id_ex_next.reg_write = 1'b0;  // NOP lands here
                endcase
            end
            `MIPS_OP_ADDI: begin
                id_ex_next.alu_src   = 1'b1;
                id_ex_next.reg_write = 1'b1;
                id_ex_next.dest      = o_rt;
            end
            `MIPS_OP_LW: begin
                id_ex_next.alu_src   = 1'b1;
                id_ex_next.mem_read  = 1'b1;
                id_ex_next.reg_write = 1'b1;
                id_ex_next.dest      = o_rt;
            end
            `MIPS_OP_SW: begin
                id_ex_next.alu_src   = 1'b1;
                id_ex_next.mem_write = 1'b1;
            end
            `MIPS_OP_BEQ: is_beq = 1'b1;
            `MIPS_OP_BNE: is_bne = 1'b1;
            default: ;                               // Halt word and unknown ops
        endcase
        if (id_ex_next.dest == '0)
            id_ex_next.reg_write = 1'b0;             // r0 stays zero
    end

    // Halt flag and ID/EX --------
    always_ff @(posedge i_clock) begin
        if (i_reset || i_pc_reset) begin
            o_halted <= 1'b0;
            o_id_ex  <= '0;
        end else begin
            if (instr == `MIPS_HALT_WORD)
                o_halted <= 1'b1;
            if (i_stall || o_halted)
                o_id_ex <= '0;                       // Bubble
            else
                o_id_ex <= id_ex_next;
        end
    end

    // Bank write at the end of WB
    always_ff @(posedge i_clock) begin
        if (i_mem_wb.reg_write)
            reg_bank[i_mem_wb.dest] <= i_mem_wb.wb_data;
    end

    assign o_debug_read_reg = (i_debug_read_reg_address == '0) ? '0
                                                              : reg_bank[i_debug_read_reg_address];

    // Write to r0 dropped here must not reappear three stages later
    a_no_r0_write: assert property (
        @(posedge i_clock) disable iff (i_reset) !(i_mem_wb.reg_write && i_mem_wb.dest == '0)
    );

endmodule

/* rtl/execution.sv */
module execution (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_pc_reset,
    input  mips_pkg::id_ex_t    i_id_ex,
    output mips_pkg::ex_mem_t   o_ex_mem,
    output mips_pkg::data_t     o_alu_result,     // Forwarded to decode
    output mips_pkg::reg_addr_t o_dest,
    output logic                o_reg_write
);

    mips_pkg::data_t alu_b;

    assign alu_b = i_id_ex.alu_src ? i_id_ex.imm : i_id_ex.op_b;

    // ALU ------------------------
    always_comb begin
        case (i_id_ex.alu_op)
            mips_pkg::ALU_ADD: o_alu_result = i_id_ex.op_a + alu_b;
            mips_pkg::ALU_SUB: o_alu_result = i_id_ex.op_a - alu_b;
            mips_pkg::ALU_AND: o_alu_result = i_id_ex.op_a & alu_b;
            mips_pkg::ALU_OR:  o_alu_result = i_id_ex.op_a | alu_b;
            mips_pkg::ALU_SLT: o_alu_result = {31'd0, $signed(i_id_ex.op_a) < $signed(alu_b)};
            default:           o_alu_result = '0;
        endcase
    end

    assign o_dest      = i_id_ex.dest;
    assign o_reg_write = i_id_ex.reg_write;

    // EX/MEM register
    always_ff @(posedge i_clock) begin
        if (i_reset || i_pc_reset) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.alu_result <= o_alu_result;
            o_ex_mem.store_data <= i_id_ex.op_b;    // rt for SW
            o_ex_mem.dest       <= i_id_ex.dest;
            o_ex_mem.mem_write  <= i_id_ex.mem_write;
            o_ex_mem.mem_read   <= i_id_ex.mem_read;
            o_ex_mem.reg_write  <= i_id_ex.reg_write;
        end
    end

    // Decode never marks one instruction as both load and store
    a_no_read_and_write: assert property (
        @(posedge i_clock) disable iff (i_reset) !(i_id_ex.mem_read && i_id_ex.mem_write)
    );

endmodule

/* rtl/memory_access.sv */
`include "mips_consts.svh"

module memory_access (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_pc_reset,
    input  mips_pkg::ex_mem_t   i_ex_mem,
    input  mips_pkg::mem_addr_t i_debug_read_mem_address,
    output mips_pkg::mem_wb_t   o_mem_wb,
    output mips_pkg::data_t     o_wb_data,        // Also forwarded to decode
    output mips_pkg::data_t     o_debug_read_mem
);

    mips_pkg::data_t     data_mem [0:(1 << `MIPS_NB_MEM_ADDR) - 1];
    mips_pkg::mem_addr_t addr;

    assign addr = i_ex_mem.alu_result[`MIPS_NB_MEM_ADDR+1:2];   // Byte address to word index

    // Data memory ----------------
    always_ff @(posedge i_clock) begin
        if (i_ex_mem.mem_write)
            data_mem[addr] <= i_ex_mem.store_data;
    end

    assign o_debug_read_mem = data_mem[i_debug_read_mem_address];

    // Write-back select, loaded word or ALU result
    assign o_wb_data = i_ex_mem.mem_read ? data_mem[addr] : i_ex_mem.alu_result;

    // MEM/WB register
    always_ff @(posedge i_clock) begin
        if (i_reset || i_pc_reset) begin
            o_mem_wb <= '0;
        end else begin
            o_mem_wb.wb_data   <= o_wb_data;
            o_mem_wb.dest      <= i_ex_mem.dest;
            o_mem_wb.reg_write <= i_ex_mem.reg_write;
        end
    end

endmodule

/* rtl/mips_top.sv */
module mips_top (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_pc_reset,
    input  mips_pkg::byte_t     i_load_program_byte,
    input  logic                i_load_program_write_enable,
    input  mips_pkg::reg_addr_t i_debug_read_reg_address,
    input  mips_pkg::mem_addr_t i_debug_read_mem_address,
    output mips_pkg::data_t     o_debug_read_reg,
    output mips_pkg::data_t     o_debug_read_mem,
    output mips_pkg::data_t     o_debug_read_pc,
    output logic                o_is_program_end
);

    mips_pkg::if_id_t    if_id;
    mips_pkg::id_ex_t    id_ex;
    mips_pkg::ex_mem_t   ex_mem;
    mips_pkg::mem_wb_t   mem_wb;

    logic                stall;            // Hazard unit to IF and ID
    logic                flush;            // Hazard unit to IF
    logic                branch_taken;     // Resolved in ID
    mips_pkg::data_t     branch_target;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::data_t     ex_result;        // EX forward source
    mips_pkg::reg_addr_t ex_dest;
    logic                ex_reg_write;
    mips_pkg::data_t     mem_result;       // MEM forward source

    // Fetch ----------------------
    instruction_fetch u_instruction_fetch (
        .i_clock                     (i_clock),
        .i_reset                     (i_reset),
        .i_pc_reset                  (i_pc_reset),
        .i_load_program_byte         (i_load_program_byte),
        .i_load_program_write_enable (i_load_program_write_enable),
        .i_stall                     (stall),
        .i_flush                     (flush),
        .i_branch_taken              (branch_taken),
        .i_branch_target             (branch_target),
        .o_if_id                     (if_id),
        .o_pc                        (o_debug_read_pc)
    );

    hazard_unit u_hazard_unit (
        .i_rs               (rs),
        .i_rt               (rt),
        .i_id_ex_mem_read   (id_ex.mem_read),
        .i_id_ex_dest       (id_ex.dest),
        .i_branch_taken     (branch_taken),
        .i_halted           (o_is_program_end),
        .o_stall            (stall),
        .o_flush            (flush)
    );

    // Decode ---------------------
    instruction_decode u_instruction_decode (
        .i_clock                  (i_clock),
        .i_reset                  (i_reset),
        .i_pc_reset               (i_pc_reset),
        .i_if_id                  (if_id),
        .i_stall                  (stall),
        .i_ex_result              (ex_result),
        .i_ex_dest                (ex_dest),
        .i_ex_reg_write           (ex_reg_write),
        .i_mem_result             (mem_result),
        .i_mem_dest               (ex_mem.dest),        // Dest of the instr in MEM
        .i_mem_reg_write          (ex_mem.reg_write),
        .i_mem_wb                 (mem_wb),
        .i_debug_read_reg_address (i_debug_read_reg_address),
        .o_id_ex                  (id_ex),
        .o_rs                     (rs),
        .o_rt                     (rt),
        .o_branch_taken           (branch_taken),
        .o_branch_target          (branch_target),
        .o_halted                 (o_is_program_end),
        .o_debug_read_reg         (o_debug_read_reg)
    );

    // Execute and memory ---------
    execution u_execution (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_pc_reset     (i_pc_reset),
        .i_id_ex        (id_ex),
        .o_ex_mem       (ex_mem),
        .o_alu_result   (ex_result),
        .o_dest         (ex_dest),
        .o_reg_write    (ex_reg_write)
    );

    memory_access u_memory_access (
        .i_clock                  (i_clock),
        .i_reset                  (i_reset),
        .i_pc_reset               (i_pc_reset),
        .i_ex_mem                 (ex_mem),
        .i_debug_read_mem_address (i_debug_read_mem_address),
        .o_mem_wb                 (mem_wb),
        .o_wb_data                (mem_result),
        .o_debug_read_mem         (o_debug_read_mem)
    );

endmodule

/* dv/tb_mips.sv */
`include "mips_consts.svh"

module tb_mips;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;   // Five tests take roughly 550 cycles

    logic                i_clock = 1'b0;
    logic                i_reset;
    logic                i_pc_reset;
    mips_pkg::byte_t     i_load_program_byte;
    logic                i_load_program_write_enable;
    mips_pkg::reg_addr_t i_debug_read_reg_address;
    mips_pkg::mem_addr_t i_debug_read_mem_address;
    mips_pkg::data_t     o_debug_read_reg;
    mips_pkg::data_t     o_debug_read_mem;
    mips_pkg::data_t     o_debug_read_pc;
    logic                o_is_program_end;

    mips_pkg::data_t     prog_words [$];     // Program image, word 0 first
    integer              seed;
    int                  error_count = 0;
    int                  check_count = 0;
    int                  cycle_count = 0;

    mips_top uut (
        .i_clock                     (i_clock),
        .i_reset                     (i_reset),
        .i_pc_reset                  (i_pc_reset),
        .i_load_program_byte         (i_load_program_byte),
        .i_load_program_write_enable (i_load_program_write_enable),
        .i_debug_read_reg_address    (i_debug_read_reg_address),
        .i_debug_read_mem_address    (i_debug_read_mem_address),
        .o_debug_read_reg            (o_debug_read_reg),
        .o_debug_read_mem            (o_debug_read_mem),
        .o_debug_read_pc             (o_debug_read_pc),
        .o_is_program_end            (o_is_program_end)
    );

    always #5 i_clock = ~i_clock;           // 10 ns period

    always @(posedge i_clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Encoding ------------------------
    function automatic mips_pkg::data_t r_instr(input logic [5:0] funct,
            input mips_pkg::reg_addr_t rd, input mips_pkg::reg_addr_t rs,
            input mips_pkg::reg_addr_t rt);
        return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic mips_pkg::data_t imm_instr(input logic [5:0] opcode,
            input mips_pkg::reg_addr_t rt, input mips_pkg::reg_addr_t rs,
            input logic [15:0] imm);
        return {opcode, rs, rt, imm};
    endfunction

    // Offset in words from the branch's PC plus 4
    function automatic mips_pkg::data_t branch_instr(input logic [5:0] opcode,
            input mips_pkg::reg_addr_t rs, input mips_pkg::reg_addr_t rt, input int offset);
        return {opcode, rs, rt, offset[15:0]};
    endfunction

    function automatic mips_pkg::data_t sext16(input logic [15:0] value);
        return {{16{value[15]}}, value};    // ADDI, LW and SW immediate
    endfunction

    // Checks --------------------------
    task automatic check_value(input string name, input mips_pkg::data_t got,
            input mips_pkg::data_t expected);
        check_count = check_count + 1;
        if (got !== expected) begin
            error_count = error_count + 1;
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_reg(input mips_pkg::reg_addr_t addr, input mips_pkg::data_t expected);
        @(posedge i_clock);
        #1 i_debug_read_reg_address = addr;
        @(negedge i_clock);                 // Read port is combinational
        check_value($sformatf("reg[%0d]", addr), o_debug_read_reg, expected);
    endtask

    task automatic check_mem(input mips_pkg::mem_addr_t addr, input mips_pkg::data_t expected);
        @(posedge i_clock);
        #1 i_debug_read_mem_address = addr;
        @(negedge i_clock);
        check_value($sformatf("mem[%0d]", addr), o_debug_read_mem, expected);
    endtask

    // Program handling
    task automatic load_program();
        @(posedge i_clock);
        #1;
        i_reset    = 1'b1;                  // Clears the loader's write pointer
        i_pc_reset = 1'b1;                  // Pipeline idle during the load
        repeat (2) begin
            @(posedge i_clock);
            #1;
        end
        i_reset = 1'b0;
        foreach (prog_words[i]) begin
            for (int b = 3; b >= 0; b--) begin
                i_load_program_byte         = prog_words[i][8*b +: 8];  // MSB first
                i_load_program_write_enable = 1'b1;
                @(posedge i_clock);
                #1;
            end
        end
        i_load_program_write_enable = 1'b0;
        i_pc_reset                  = 1'b0; // Restart from address 0
    endtask

    task automatic wait_for_halt();
        while (o_is_program_end !== 1'b1)
            @(negedge i_clock);
        repeat (4) @(posedge i_clock);      // Drain EX, MEM and WB
    endtask

    // Tests ---------------------------
    task automatic arith_logic_test();
        integer          rnd;
        logic [15:0]     ia;
        logic [15:0]     ib;
        logic [15:0]     ic;
        mips_pkg::data_t va;
        mips_pkg::data_t vb;
        mips_pkg::data_t vc;
        mips_pkg::data_t sum;
        mips_pkg::data_t diff;
        mips_pkg::data_t conj;
        rnd = $random(seed);
        ia  = rnd[15:0];
        rnd = $random(seed);
        ib  = rnd[15:0];
        rnd = $random(seed);
        ic  = {1'b1, rnd[14:0]};           // Always negative
        va  = sext16(ia);
        vb  = sext16(ib);
        vc  = sext16(ic);
        sum  = va + vb;
        diff = sum - va;
        conj = diff & sum;
        prog_words = {};
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 1, 0, ia));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 2, 0, ib));
        prog_words.push_back(r_instr(`MIPS_FN_ADDU, 3, 1, 2));   // r2 from EX, r1 from MEM
        prog_words.push_back(r_instr(`MIPS_FN_SUBU, 4, 3, 1));   // r1 from WB
        prog_words.push_back(r_instr(`MIPS_FN_AND, 5, 4, 3));
        prog_words.push_back(r_instr(`MIPS_FN_OR, 6, 5, 2));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 7, 0, ic));
        prog_words.push_back(r_instr(`MIPS_FN_SLT, 8, 7, 1));
        prog_words.push_back(r_instr(`MIPS_FN_SLT, 9, 1, 7));
        prog_words.push_back(`MIPS_HALT_WORD);
        load_program();
        wait_for_halt();
        check_reg(3, sum);
        check_reg(4, diff);
        check_reg(5, conj);
        check_reg(6, conj | vb);
        check_reg(7, vc);
        check_reg(8, ($signed(vc) < $signed(va)) ? 32'd1 : 32'd0);
        check_reg(9, ($signed(va) < $signed(vc)) ? 32'd1 : 32'd0);
    endtask

    task automatic memory_test();
        mips_pkg::data_t x1;
        mips_pkg::data_t x2;
        x1 = sext16(16'h1234);
        x2 = sext16(16'h8ABC);
        prog_words = {};
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 1, 0, 16'h1234));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 2, 0, 16'h8ABC));
        prog_words.push_back(r_instr(`MIPS_FN_ADDU, 3, 1, 2));
        prog_words.push_back(imm_instr(`MIPS_OP_SW, 3, 0, 16'd8));   // Word 2
        prog_words.push_back(imm_instr(`MIPS_OP_SW, 1, 0, 16'd12));  // Word 3
        prog_words.push_back(imm_instr(`MIPS_OP_LW, 4, 0, 16'd8));
        prog_words.push_back(r_instr(`MIPS_FN_ADDU, 5, 4, 4));      // Load-use stall
        prog_words.push_back(imm_instr(`MIPS_OP_LW, 6, 0, 16'd12));
        prog_words.push_back(imm_instr(`MIPS_OP_SW, 6, 0, 16'd20));  // Store of loaded word
        prog_words.push_back(imm_instr(`MIPS_OP_SW, 5, 0, 16'd16));
        prog_words.push_back(`MIPS_HALT_WORD);
        load_program();
        wait_for_halt();
        check_reg(4, x1 + x2);
        check_reg(5, (x1 + x2) + (x1 + x2));
        check_reg(6, x1);
        check_mem(2, x1 + x2);
        check_mem(3, x1);
        check_mem(4, (x1 + x2) + (x1 + x2));
        check_mem(5, x1);
    endtask

    task automatic branch_test();
        integer      rnd;
        logic [15:0] bound;
        rnd   = $random(seed);
        bound = {13'd0, rnd[2:0]} + 16'd2;  // 2 to 9 passes
        prog_words = {};
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 1, 0, 16'd5));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 2, 0, 16'd5));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 3, 0, 16'd0));
        prog_words.push_back(branch_instr(`MIPS_OP_BEQ, 1, 2, 1));   // Taken
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 3, 0, 16'd99)); // Skipped
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 4, 0, 16'd7));
        prog_words.push_back(branch_instr(`MIPS_OP_BNE, 1, 2, 1));   // Not taken
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 5, 0, 16'd11));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 6, 0, 16'd0));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 7, 0, bound));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 6, 6, 16'd1)); // Loop body, word 10
        prog_words.push_back(branch_instr(`MIPS_OP_BNE, 6, 7, -2));  // Back to word 10
        prog_words.push_back(`MIPS_HALT_WORD);
        load_program();
        wait_for_halt();
        check_reg(3, 32'd0);
        check_reg(4, 32'd7);
        check_reg(5, 32'd11);
        check_reg(6, sext16(bound));
    endtask

    task automatic r0_test();
        prog_words = {};
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 0, 0, 16'd123));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 1, 0, 16'd55));
        prog_words.push_back(r_instr(`MIPS_FN_ADDU, 0, 1, 1));
        prog_words.push_back(r_instr(`MIPS_FN_ADDU, 2, 0, 1));      // r0 must read zero
        prog_words.push_back(`MIPS_HALT_WORD);
        load_program();
        wait_for_halt();
        check_reg(0, 32'd0);
        check_reg(2, 32'd55);
    endtask

    task automatic halt_restart_test();
        // Short program that zeroes the result registers first
        prog_words = {};
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 10, 0, 16'd0));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 11, 0, 16'd0));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 12, 0, 16'd0));
        prog_words.push_back(`MIPS_HALT_WORD);
        load_program();
        wait_for_halt();
        check_reg(12, 32'd0);
        prog_words = {};
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 10, 0, 16'd21));
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 11, 10, 16'd21));
        prog_words.push_back(`MIPS_HALT_WORD);
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 12, 0, 16'd77)); // Never runs
        prog_words.push_back(imm_instr(`MIPS_OP_ADDI, 10, 0, 16'd1));
        load_program();
        wait_for_halt();
        check_reg(10, 32'd21);
        check_reg(11, 32'd42);
        check_reg(12, 32'd0);
        check_value("o_is_program_end", {31'd0, o_is_program_end}, 32'd1);
        // Restart, program stays in memory
        @(posedge i_clock);
        #1 i_pc_reset = 1'b1;
        @(posedge i_clock);
        #1 i_pc_reset = 1'b0;
        @(negedge i_clock);
        check_value("o_is_program_end", {31'd0, o_is_program_end}, 32'd0);
        check_value("o_debug_read_pc", o_debug_read_pc, 32'd0);
        wait_for_halt();
        check_reg(10, 32'd21);
        check_reg(11, 32'd42);
        check_reg(12, 32'd0);
    endtask

    initial begin
        seed                        = 82517;
        i_reset                     = 1'b1;
        i_pc_reset                  = 1'b1;
        i_load_program_byte         = '0;
        i_load_program_write_enable = 1'b0;
        i_debug_read_reg_address    = '0;
        i_debug_read_mem_address    = '0;
        repeat (2) @(posedge i_clock);      // Power-on reset, two cycles
        #1;
        i_reset    = 1'b0;
        i_pc_reset = 1'b0;

        arith_logic_test();
        memory_test();
        branch_test();
        r0_test();
        halt_restart_test();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
rtl/mips_pkg.sv
rtl/hazard_unit.sv
rtl/instruction_fetch.sv
rtl/instruction_decode.sv
rtl/execution.sv
rtl/memory_access.sv
rtl/mips_top.sv
dv/tb_mips.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run tb_mips with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

sim_out=$(verilator --binary --timing --assert --top-module tb_mips -f verilog.f \
        -o tb_mips_sim 2>&1 \
    && ./obj_dir/tb_mips_sim 2>&1)

echo "$sim_out"
echo "$sim_out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
